// ==== common/conv_weights_settings.svh ====
`ifndef CONV_WEIGHTS_SETTINGS_SVH
`define CONV_WEIGHTS_SETTINGS_SVH

////////////////////
// weight format
////////////////////

`define WEIGHT_BITS       8   // one 8 bit weight
`define WEIGHTS_PER_WORD  8   // weights in one buffer word
`define WEIGHT_WORD_BITS  (`WEIGHT_BITS * `WEIGHTS_PER_WORD)

// ddr side
`define BEAT_BITS         16
`define BEATS_PER_WORD    (`WEIGHT_WORD_BITS / `BEAT_BITS)

////////////////////
// buffer geometry
////////////////////

`define BUF_ADR_BITS      16  // wide address like the ddr path
`define BUF_DEPTH         64  // words per ping or pong buffer
`define TILE_LEN_BITS     7   // holds 1 to 64

`endif

// ==== common/conv_weights_pkg.sv ====
`include "conv_weights_settings.svh"

package conv_weights_pkg;

  ////////////////////
  // data types
  ////////////////////

  // one full buffer word, weights packed low first
  typedef logic [`WEIGHT_WORD_BITS-1:0] weight_word_t;

  // narrow beat as it comes from ddr
  typedef logic [`BEAT_BITS-1:0] ddr_beat_t;

  // address into either buffer
  typedef logic [`BUF_ADR_BITS-1:0] buf_adr_t;

  // words per tile
  typedef logic [`TILE_LEN_BITS-1:0] tile_len_t;

  ////////////////////
  // fsm encodings
  ////////////////////

  // tile reader
  typedef enum logic {
    IDLE,  // waiting for rd_start
    READ   // issuing addresses
  } reader_state_t;

endpackage

// ==== weight_buf/conv_weights_ping_pong_controller.sv ====
module conv_weights_ping_pong_controller (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            conv_load_weights,  // swap pulse

  // write side, from the loader
  input  logic                            wt_en,
  input  conv_weights_pkg::buf_adr_t      wt_adr,
  input  conv_weights_pkg::weight_word_t  wt_word,

  // read side, from and to the reader
  input  logic                            rd_en,
  input  conv_weights_pkg::buf_adr_t      rd_adr,
  output conv_weights_pkg::weight_word_t  rd_word,

  // ping buffer
  output logic                            ping_en,
  output logic                            ping_en_wr,
  output conv_weights_pkg::buf_adr_t      ping_adr,
  output conv_weights_pkg::weight_word_t  ping_din,
  input  conv_weights_pkg::weight_word_t  ping_dout,

  // pong buffer
  output logic                            pong_en,
  output logic                            pong_en_wr,
  output conv_weights_pkg::buf_adr_t      pong_adr,
  output conv_weights_pkg::weight_word_t  pong_din,
  input  conv_weights_pkg::weight_word_t  pong_dout
);

  logic wr_sel;  // low writes ping, high writes pong
  logic rd_sel;  // low reads ping, high reads pong

  ////////////////////
  // buffer role select
  ////////////////////

  // out of reset fill ping, read the empty pong
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_sel <= 1'b0;
      rd_sel <= 1'b1;
    end
    else if (conv_load_weights)
    begin
      wr_sel <= ~wr_sel;  // freshly loaded tile becomes readable
      rd_sel <= ~rd_sel;
    end
  end

  ////////////////////
  // port steering
  ////////////////////

  // write port has priority, read port goes to the other buffer
  assign ping_en    = (wr_sel == 1'b0) ? wt_en : (rd_sel == 1'b0) ? rd_en : 1'b0;
  assign ping_en_wr = (wr_sel == 1'b0) ? wt_en : 1'b0;
  assign ping_adr   = (wr_sel == 1'b0) ? wt_adr : (rd_sel == 1'b0) ? rd_adr : '0;
  assign ping_din   = (wr_sel == 1'b0) ? wt_word : '0;  // zero when not writing

  assign pong_en    = (wr_sel == 1'b1) ? wt_en : (rd_sel == 1'b1) ? rd_en : 1'b0;
  assign pong_en_wr = (wr_sel == 1'b1) ? wt_en : 1'b0;
  assign pong_adr   = (wr_sel == 1'b1) ? wt_adr : (rd_sel == 1'b1) ? rd_adr : '0;
  assign pong_din   = (wr_sel == 1'b1) ? wt_word : '0;

  // read data mux, one cycle after the read
  // swaps are kept away from a running tile so rd_sel is stable here
  assign rd_word = rd_sel ? pong_dout : ping_dout;

endmodule

// ==== weight_buf/weight_buf_ram.sv ====
`include "conv_weights_settings.svh"

module weight_buf_ram (
  input  logic                            clk,
  input  logic                            en,     // port enable
  input  logic                            en_wr,  // write when set with en
  input  conv_weights_pkg::buf_adr_t      adr,
  input  conv_weights_pkg::weight_word_t  din,
  output conv_weights_pkg::weight_word_t  dout
);

  import conv_weights_pkg::*;

  localparam int IDX_BITS = $clog2(`BUF_DEPTH);

  weight_word_t         mem [`BUF_DEPTH];  // storage, no reset
  logic [IDX_BITS-1:0]  idx;

  // only the low bits select a word
  assign idx = adr[IDX_BITS-1:0];

  ////////////////////
  // single port access
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (en)
    begin
      if (en_wr)
        mem[idx] <= din;   // write, dout holds
      else
        dout <= mem[idx];  // registered read, valid next cycle
    end
  end

endmodule

// ==== verilog/weight_word_loader.sv ====
`include "conv_weights_settings.svh"

module weight_word_loader (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            conv_load_weights,  // swap, restarts the fill
  input  logic                            beat_valid,
  input  conv_weights_pkg::ddr_beat_t     beat,
  output logic                            wt_en,    // one cycle write strobe
  output conv_weights_pkg::buf_adr_t      wt_adr,
  output conv_weights_pkg::weight_word_t  wt_word
);

  import conv_weights_pkg::*;

  localparam int CNT_BITS = $clog2(`BEATS_PER_WORD);

  logic [CNT_BITS-1:0] beat_cnt;   // beats already in pack_q
  weight_word_t        pack_q;     // word under assembly
  logic                word_done;  // this beat completes a word

  assign word_done = beat_valid && (beat_cnt == CNT_BITS'(`BEATS_PER_WORD - 1));

  ////////////////////
  // beat packing
  ////////////////////

  // shift right so the first beat ends up in the low bits
  always_ff @(posedge clk)
  begin
    if (beat_valid && !conv_load_weights)  // beat in swap cycle dropped
      pack_q <= {beat, pack_q[`WEIGHT_WORD_BITS-1:`BEAT_BITS]};
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      beat_cnt <= '0;
    else if (conv_load_weights)
      beat_cnt <= '0;  // partial word discarded
    else if (word_done)
      beat_cnt <= '0;
    else if (beat_valid)
      beat_cnt <= beat_cnt + 1'b1;
  end

  ////////////////////
  // write strobe, address
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wt_en  <= 1'b0;
      wt_adr <= '0;
    end
    else
    begin
      wt_en <= word_done && !conv_load_weights;  // cycle after last beat
      if (conv_load_weights)
        wt_adr <= '0;             // next fill starts at word 0
      else if (wt_en)
        wt_adr <= wt_adr + 1'b1;  // move on after each write
    end
  end

  // packed word is stable during the strobe cycle
  assign wt_word = pack_q;

endmodule

// ==== verilog/weight_tile_reader.sv ====
module weight_tile_reader (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            rd_start,    // one cycle start pulse
  input  conv_weights_pkg::tile_len_t     tile_words,  // 1 to 64
  input  conv_weights_pkg::weight_word_t  rd_word,     // from the read buffer
  output logic                            rd_en,
  output conv_weights_pkg::buf_adr_t      rd_adr,
  output logic                            weight_valid,
  output conv_weights_pkg::weight_word_t  weight_word,
  output logic                            rd_busy
);

  import conv_weights_pkg::*;

  reader_state_t state;
  tile_len_t     len_q;     // latched tile length
  buf_adr_t      last_adr;  // address of the final word
  logic          start_ok;  // start accepted

  // starts during a running tile are ignored
  assign start_ok = rd_start && !rd_busy;

  assign last_adr = buf_adr_t'(len_q) - buf_adr_t'(1);

  ////////////////////
  // address fsm
  ////////////////////

  // tile length taken on an accepted start
  always_ff @(posedge clk)
  begin
    if (start_ok)
      len_q <= tile_words;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state  <= IDLE;
      rd_adr <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (start_ok)
          begin
            state  <= READ;
            rd_adr <= '0;  // every tile starts at word 0
          end
        end
        READ:
        begin
          if (rd_adr == last_adr)
            state <= IDLE;            // last address issued
          else
            rd_adr <= rd_adr + 1'b1;  // one word per cycle
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign rd_en = (state == READ);

  ////////////////////
  // output pipeline
  ////////////////////

  // valid lines up with the buffer's registered dout
  always_ff @(posedge clk)
  begin
    if (reset)
      weight_valid <= 1'b0;
    else
      weight_valid <= rd_en;
  end

  assign weight_word = rd_word;              // straight from the buffer
  assign rd_busy     = rd_en || weight_valid;  // covers the last word in flight

endmodule

// ==== verilog/conv_weights_top.sv ====
module conv_weights_top (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            conv_load_weights,  // swap ping and pong

  // ddr beats in
  input  logic                            beat_valid,
  input  conv_weights_pkg::ddr_beat_t     beat,

  // tile read control
  input  logic                            rd_start,
  input  conv_weights_pkg::tile_len_t     tile_words,

  // words to the compute array
  output logic                            weight_valid,
  output conv_weights_pkg::weight_word_t  weight_word,
  output logic                            rd_busy
);

  import conv_weights_pkg::*;

  ////////////////////
  // internal wires
  ////////////////////

  // loader to controller
  logic         wt_en;
  buf_adr_t     wt_adr;
  weight_word_t wt_word;

  // reader and controller
  logic         rd_en;
  buf_adr_t     rd_adr;
  weight_word_t rd_word;

  // controller to ping
  logic         ping_en;
  logic         ping_en_wr;
  buf_adr_t     ping_adr;
  weight_word_t ping_din;
  weight_word_t ping_dout;

  // controller to pong
  logic         pong_en;
  logic         pong_en_wr;
  buf_adr_t     pong_adr;
  weight_word_t pong_din;
  weight_word_t pong_dout;

  ////////////////////
  // write path
  ////////////////////

  weight_word_loader u_loader (
    .clk               (clk),
    .reset             (reset),
    .conv_load_weights (conv_load_weights),
    .beat_valid        (beat_valid),
    .beat              (beat),
    .wt_en             (wt_en),
    .wt_adr            (wt_adr),
    .wt_word           (wt_word)
  );

  conv_weights_ping_pong_controller u_ctrl (
    .clk (clk), .reset (reset), .conv_load_weights (conv_load_weights),
    .wt_en (wt_en), .wt_adr (wt_adr), .wt_word (wt_word),
    .rd_en (rd_en), .rd_adr (rd_adr), .rd_word (rd_word),
    .ping_en (ping_en), .ping_en_wr (ping_en_wr), .ping_adr (ping_adr),
    .ping_din (ping_din), .ping_dout (ping_dout),
    .pong_en (pong_en), .pong_en_wr (pong_en_wr), .pong_adr (pong_adr),
    .pong_din (pong_din), .pong_dout (pong_dout)
  );

  // the two buffers, roles swap every conv_load_weights
  weight_buf_ram u_ping_buf (
    .clk (clk), .en (ping_en), .en_wr (ping_en_wr),
    .adr (ping_adr), .din (ping_din), .dout (ping_dout)
  );

  weight_buf_ram u_pong_buf (
    .clk (clk), .en (pong_en), .en_wr (pong_en_wr),
    .adr (pong_adr), .din (pong_din), .dout (pong_dout)
  );

  ////////////////////
  // read path
  ////////////////////

  weight_tile_reader u_reader (
    .clk (clk), .reset (reset),
    .rd_start (rd_start), .tile_words (tile_words), .rd_word (rd_word),
    .rd_en (rd_en), .rd_adr (rd_adr),
    .weight_valid (weight_valid), .weight_word (weight_word), .rd_busy (rd_busy)
  );

endmodule

// ==== bench/conv_weights_assert.sv ====
module conv_weights_assert (
  input logic clk,
  input logic reset,
  input logic rd_sel,      // high reads pong
  input logic ping_en,
  input logic ping_en_wr,
  input logic pong_en,
  input logic pong_en_wr
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////
  // buffer write rules
  ////////////////////

  // only one buffer takes the write port
  a_one_writer: assert property (@(posedge clk) disable iff (reset)
    !(ping_en_wr && pong_en_wr))
    else $error("ping and pong were written in the same cycle");

  // never write the buffer being read
  a_ping_read_only: assert property (@(posedge clk) disable iff (reset)
    !(ping_en_wr && !rd_sel))
    else $error("ping was written while selected for reading");

  a_pong_read_only: assert property (@(posedge clk) disable iff (reset)
    !(pong_en_wr && rd_sel))
    else $error("pong was written while selected for reading");

  ////////////////////
  // quiet enables
  ////////////////////

  a_reset_quiet: assert property (@(posedge clk) $fell(reset) |-> (!ping_en && !pong_en))
    else $error("a buffer enable was high right after reset");

endmodule

// attach to every controller instance
bind conv_weights_ping_pong_controller conv_weights_assert u_assert (
  .clk        (clk),
  .reset      (reset),
  .rd_sel     (rd_sel),
  .ping_en    (ping_en),
  .ping_en_wr (ping_en_wr),
  .pong_en    (pong_en),
  .pong_en_wr (pong_en_wr)
);

// ==== bench/conv_weights_tb.sv ====
`include "conv_weights_settings.svh"

module conv_weights_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import conv_weights_pkg::*;

  localparam int IDX_BITS   = $clog2(`BUF_DEPTH);
  localparam int ROUNDS     = 6;                        // random rounds in test 4
  localparam int LOAD_WORDS = 8 + 8 + ROUNDS * 16 + 4 + 10;
  localparam int READ_WORDS = 8 + 8 + 8 + ROUNDS * 16 + 4 + 10;
  localparam int TILES      = 5 + ROUNDS;
  // gap before each beat at most doubles the load time
  localparam int STIM_CYCLES = 10 + 20 + LOAD_WORDS * `BEATS_PER_WORD * 2
                               + READ_WORDS + TILES * 8 + 20;
  localparam int WATCHDOG_CYCLES = STIM_CYCLES * 2 + 200;

  typedef logic [IDX_BITS-1:0] idx_t;

  logic         clk = 1'b0;
  logic         reset;
  logic         conv_load_weights;
  logic         beat_valid;
  ddr_beat_t    beat;
  logic         rd_start;
  tile_len_t    tile_words;
  logic         weight_valid;
  weight_word_t weight_word;
  logic         rd_busy;

  // reference model state
  weight_word_t model_mem [2][`BUF_DEPTH];  // [0] ping, [1] pong
  logic         model_wr_sel;               // buffer being filled
  weight_word_t model_pack;
  int           model_cnt;
  idx_t         model_adr;

  string test_name = "reset";
  int    err_cnt   = 0;
  int    chk_cnt   = 0;
  int    valid_cnt = 0;  // words seen on weight_valid
  idx_t  exp_adr;

  conv_weights_top u_dut (
    .clk (clk), .reset (reset), .conv_load_weights (conv_load_weights),
    .beat_valid (beat_valid), .beat (beat),
    .rd_start (rd_start), .tile_words (tile_words),
    .weight_valid (weight_valid), .weight_word (weight_word), .rd_busy (rd_busy)
  );

  always #5 clk = ~clk;  // 100 MHz

  ////////////////////
  // reference model
  ////////////////////

  // low beat first, a full word lands at the next address
  task automatic pack_model_beat(input ddr_beat_t b);
    model_pack = {b, model_pack[`WEIGHT_WORD_BITS-1:`BEAT_BITS]};
    model_cnt++;
    if (model_cnt == `BEATS_PER_WORD)
    begin
      model_mem[model_wr_sel][model_adr] = model_pack;
      model_adr = model_adr + idx_t'(1);
      model_cnt = 0;
    end
  endtask

  task automatic swap_model();
    model_wr_sel = ~model_wr_sel;
    model_cnt    = 0;  // partial word lost
    model_adr    = '0;
  endtask

  // read side is always the buffer not being filled
  function automatic weight_word_t expected_word(input idx_t adr);
    return model_mem[~model_wr_sel][adr];
  endfunction

  ////////////////////
  // stimulus tasks
  ////////////////////

  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;  // drive just after the edge
    end
  endtask

  task automatic send_beats(input int n);
    ddr_beat_t b;
    for (int k = 0; k < n; k++)
    begin
      if ($urandom % 4 == 0)
      begin
        beat_valid = 1'b0;  // random idle gap
        wait_cycles(1);
      end
      b          = ddr_beat_t'($urandom);
      beat_valid = 1'b1;
      beat       = b;
      pack_model_beat(b);
      wait_cycles(1);
    end
    beat_valid = 1'b0;
  endtask

  task automatic load_words(input int n);
    send_beats(n * `BEATS_PER_WORD);
  endtask

  task automatic swap_buffers(input logic with_beat);
    conv_load_weights = 1'b1;
    if (with_beat)
    begin
      beat_valid = 1'b1;  // dut must drop this one
      beat       = ddr_beat_t'($urandom);
    end
    swap_model();
    wait_cycles(1);
    conv_load_weights = 1'b0;
    beat_valid        = 1'b0;
  endtask

  // optional second start while busy, must be ignored
  task automatic read_tile(input int len, input logic poke_busy);
    int start_cnt;
    int cyc;
    start_cnt  = valid_cnt;
    rd_start   = 1'b1;
    tile_words = tile_len_t'(len);
    wait_cycles(1);
    rd_start = 1'b0;
    cyc      = 0;
    while (rd_busy)
    begin
      // first word two cycles after the start pulse
      if (cyc < 2)
      begin
        chk_cnt++;
        assert (weight_valid == (cyc == 1))
        else
        begin
          err_cnt++;
          $display("error %s: valid at cycle %0d expected %b actual %b",
                   test_name, cyc + 1, (cyc == 1), weight_valid);
        end
      end
      if (poke_busy && cyc == 2)
      begin
        rd_start   = 1'b1;
        tile_words = tile_len_t'(len + 5);
      end
      else
        rd_start = 1'b0;
      wait_cycles(1);
      cyc++;
    end
    rd_start = 1'b0;
    chk_cnt++;
    assert (valid_cnt - start_cnt == len)
    else
    begin
      err_cnt++;
      $display("error %s: word count expected %0d actual %0d",
               test_name, len, valid_cnt - start_cnt);
    end
    wait_cycles(2);  // keep swaps clear of the tile end
  endtask

  task automatic check_idle(input int n);
    repeat (n)
    begin
      chk_cnt++;
      assert (!weight_valid && !rd_busy)
      else
      begin
        err_cnt++;
        $display("error %s: valid,busy expected 00 actual %b%b",
                 test_name, weight_valid, rd_busy);
      end
      wait_cycles(1);
    end
  endtask

  ////////////////////
  // output compare
  ////////////////////

  // sample mid cycle, away from the edge
  always @(negedge clk)
  begin
    weight_word_t exp;
    if (reset || !weight_valid)
      exp_adr = '0;  // every tile starts at word 0
    else
    begin
      exp = expected_word(exp_adr);
      chk_cnt++;
      assert (weight_word == exp)
      else
      begin
        err_cnt++;
        $display("error %s: adr %0d expected %h actual %h",
                 test_name, exp_adr, exp, weight_word);
      end
      exp_adr = exp_adr + idx_t'(1);
      valid_cnt++;
    end
  end

  ////////////////////
  // watchdog
  ////////////////////

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial
  begin
    int len;
    void'($urandom(32'h1a11_1995));
    reset             = 1'b1;
    conv_load_weights = 1'b0;
    beat_valid        = 1'b0;
    beat              = '0;
    rd_start          = 1'b0;
    tile_words        = '0;
    model_wr_sel      = 1'b0;  // ping fills first
    model_pack        = '0;
    model_cnt         = 0;
    model_adr         = '0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    test_name = "idle";
    check_idle(8);

    test_name = "basic";
    load_words(8);
    swap_buffers(1'b0);
    read_tile(8, 1'b0);

    // tile A read from ping while B fills pong
    test_name = "overlap";
    fork
      read_tile(8, 1'b0);
      load_words(8);
    join
    swap_buffers(1'b0);
    read_tile(8, 1'b0);

    test_name = "rounds";
    for (int r = 0; r < ROUNDS; r++)
    begin
      len = 1 + int'($urandom % 16);
      load_words(len);
      swap_buffers(1'b0);
      read_tile(len, 1'b0);
    end

    // half a word, then a swap with a beat in it
    test_name = "partial";
    send_beats(2);
    swap_buffers(1'b1);
    load_words(4);
    swap_buffers(1'b0);
    read_tile(4, 1'b0);

    test_name = "busy_start";
    load_words(10);
    swap_buffers(1'b0);
    read_tile(10, 1'b1);
    check_idle(4);

    $display("summary: %0d errors in %0d checks", err_cnt, chk_cnt);
    if (err_cnt == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+common
common/conv_weights_pkg.sv
weight_buf/conv_weights_ping_pong_controller.sv
weight_buf/weight_buf_ram.sv
verilog/weight_word_loader.sv
verilog/weight_tile_reader.sv
verilog/conv_weights_top.sv
bench/conv_weights_assert.sv
bench/conv_weights_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the weight path testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sim.f \
  --top-module conv_weights_tb \
  -o conv_weights_sim

# show the output and pass only if the pass line is in it
./obj_dir/conv_weights_sim | tee /dev/stderr | grep "All checks passed" > /dev/null
echo "simulation passed"
